// File: game_consts.svh
// Game console constants
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

`define H_ACTIVE   64                 // Visible pixels per line
`define H_FRONT    2
`define H_SYNC     4
`define H_BACK     2
`define H_TOTAL    (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define V_ACTIVE   48                 // Visible lines per frame
`define V_FRONT    1
`define V_SYNC     2
`define V_BACK     1
`define V_TOTAL    (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define SPRITE_W   8                  // Player box size
`define SPRITE_H   8
`define P1_Y       10'd8              // Fixed player rows
`define P2_Y       10'd32

`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`define ADDR_CTRL  13'h1000           // Start of IO space
`define ADDR_P1    13'h1001
`define ADDR_P2    13'h1002

`define OP_R       5'b00000
`define OP_J       5'b00001
`define OP_BNE     5'b00010
`define OP_ADDI    5'b00101
`define OP_SW      5'b00111
`define OP_LW      5'b01000

`define ALU_ADD    3'd0               // Same as low bits of R-type funct
`define ALU_SUB    3'd1
`define ALU_AND    3'd2
`define ALU_OR     3'd3
`define ALU_SLL    3'd4
`define ALU_SRA    3'd5
`define ALU_SLT    3'd6

`define WB_ALU     2'd0               // Write-back sources
`define WB_MEM     2'd1
`define WB_PC1     2'd2

`define COLOR_BG   24'h203048
`define COLOR_P1   24'hE03020
`define COLOR_P2   24'h20A0E0

`endif

// File: game_pkg.sv
// Game console shared types
package game_pkg;

	// Register format
	typedef struct packed {
		logic [4:0] opcode;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] shamt;
		logic [6:0] funct;   // Low 3 bits pick the ALU op
	} r_fmt_t;

	// Immediate format, also used for jumps
	typedef struct packed {
		logic [4:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [16:0] imm;    // Sign-extended by datapath
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;       // Control unit view
		i_fmt_t i_fmt;       // Datapath view
	} instr_u;

	typedef struct packed {
		logic       pc_en;       // Last cycle of an instruction
		logic       ir_en;
		logic       reg_we;
		logic       mem_we;
		logic       alu_src_imm;
		logic [2:0] alu_op;
		logic [1:0] wb_sel;
		logic       branch;      // Taken bne
		logic       jump;
	} cpu_ctrl_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;  // Inside visible area
		logic       hs;      // Active low
		logic       vs;      // Active low
	} vga_pos_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} player_t;

endpackage

// File: cpu_control.sv
// Multicycle CPU control FSM
`timescale 1ns/1ps
`include "game_consts.svh"

module cpu_control (
	input  logic               clock,
	input  logic               rst_n,
	input  game_pkg::instr_u   instr,   // Current IR
	input  logic               zero,    // ALU result is zero
	output game_pkg::cpu_ctrl_t ctrl
);

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB
	} state_t;

	state_t state;
	state_t state_nx;
	logic   is_r;
	logic   is_addi;
	logic   is_lw;
	logic   is_sw;
	logic   is_bne;
	logic   is_j;

	assign is_r    = (instr.r_fmt.opcode == `OP_R);
	assign is_addi = (instr.r_fmt.opcode == `OP_ADDI);
	assign is_lw   = (instr.r_fmt.opcode == `OP_LW);
	assign is_sw   = (instr.r_fmt.opcode == `OP_SW);
	assign is_bne  = (instr.r_fmt.opcode == `OP_BNE);
	assign is_j    = (instr.r_fmt.opcode == `OP_J);

	always_comb begin
		case (state)
			S_FETCH:  state_nx = S_DECODE;
			S_DECODE: state_nx = S_EXEC;
			S_EXEC:   state_nx = (is_lw || is_sw) ? S_MEM : S_WB; // Memory ops take one more
			S_MEM:    state_nx = S_WB;
			default:  state_nx = S_FETCH;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= S_FETCH;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		ctrl = '0;
		// ALU setup held for the whole instruction so zero stays valid in writeback
		if (is_r) begin
			ctrl.alu_op = instr.r_fmt.funct[2:0];
		end else if (is_bne) begin
			ctrl.alu_op = `ALU_SUB;     // Compare rd and rs
		end else begin
			ctrl.alu_op = `ALU_ADD;     // Address or immediate add
		end
		ctrl.alu_src_imm = is_addi || is_lw || is_sw;
		ctrl.wb_sel      = is_lw ? `WB_MEM : `WB_ALU;
		case (state)
			S_DECODE: ctrl.ir_en  = 1'b1;   // Latch word, read operands
			S_MEM:    ctrl.mem_we = is_sw;
			S_WB: begin
				ctrl.pc_en  = 1'b1;
				ctrl.reg_we = is_r || is_addi || is_lw;
				ctrl.branch = is_bne && !zero;
				ctrl.jump   = is_j;
			end
			default: ;
		endcase
	end

endmodule

// File: cpu_datapath.sv
// Multicycle CPU datapath
`timescale 1ns/1ps
`include "game_consts.svh"

module cpu_datapath (
	input  logic                clock,
	input  logic                rst_n,
	input  game_pkg::cpu_ctrl_t ctrl,
	input  logic [31:0]         imem_q,
	input  logic [31:0]         reg_a,
	input  logic [31:0]         reg_b,
	input  logic [31:0]         dmem_q,
	output game_pkg::instr_u    instr,
	output logic                zero,
	output logic [11:0]         imem_addr,
	output logic [4:0]          rs_addr,
	output logic [4:0]          rt_addr,
	output logic [4:0]          rd_addr,
	output logic [31:0]         wr_data,
	output logic                reg_we,
	output logic [12:0]         dmem_addr,
	output logic [31:0]         dmem_wdata,
	output logic                mem_we
);

	logic [11:0]      pc;
	logic [11:0]      pc_inc;
	game_pkg::instr_u ir;
	game_pkg::instr_u cur;      // Word being decoded for operand reads
	logic [31:0]      a_q;
	logic [31:0]      b_q;
	logic [31:0]      alu_b;
	logic [31:0]      alu_res;
	logic [31:0]      alu_out;
	logic [31:0]      imm_ext;

	assign pc_inc    = pc + 12'd1;
	assign imem_addr = pc;
	assign instr     = ir;
	assign cur       = ctrl.ir_en ? game_pkg::instr_u'(imem_q) : ir; // ROM word during decode

	// Operand addresses, R-type uses rt, others read rd as second operand
	assign rs_addr = cur.i_fmt.rs;
	assign rt_addr = (cur.r_fmt.opcode == `OP_R) ? cur.r_fmt.rt : cur.i_fmt.rd;
	assign rd_addr = ir.i_fmt.rd;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.ir_en) begin
				ir <= imem_q;
			end
			if (ctrl.pc_en) begin
				if (ctrl.jump) begin
					pc <= ir.i_fmt.imm[11:0];           // Absolute target
				end else if (ctrl.branch) begin
					pc <= pc_inc + imm_ext[11:0];       // Relative to PC+1
				end else begin
					pc <= pc_inc;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.ir_en) begin
			a_q <= reg_a;
			b_q <= reg_b;
		end
		alu_out <= alu_res;     // Inputs stay fixed after decode
	end

	assign imm_ext = {{15{ir.i_fmt.imm[16]}}, ir.i_fmt.imm};
	assign alu_b   = ctrl.alu_src_imm ? imm_ext : b_q;

	always_comb begin
		case (ctrl.alu_op)
			`ALU_ADD: alu_res = a_q + alu_b;
			`ALU_SUB: alu_res = a_q - alu_b;
			`ALU_AND: alu_res = a_q & alu_b;
			`ALU_OR:  alu_res = a_q | alu_b;
			`ALU_SLL: alu_res = a_q << ir.r_fmt.shamt;
			`ALU_SRA: alu_res = $signed(a_q) >>> ir.r_fmt.shamt;
			`ALU_SLT: alu_res = {31'd0, $signed(a_q) < $signed(alu_b)};
			default:  alu_res = a_q + alu_b;
		endcase
	end

	assign zero = (alu_res == 32'd0);   // Used by bne in writeback

	always_comb begin
		case (ctrl.wb_sel)
			`WB_MEM: wr_data = dmem_q;
			default: wr_data = alu_out;
		endcase
	end

	assign reg_we     = ctrl.reg_we;
	assign mem_we     = ctrl.mem_we;
	assign dmem_addr  = alu_out[12:0];
	assign dmem_wdata = b_q;    // Store data from rd

endmodule

// File: regfile.sv
// CPU register file
`timescale 1ns/1ps

module regfile (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  wr_addr,
	input  logic [4:0]  rd_addr_a,
	input  logic [4:0]  rd_addr_b,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data_a,
	output logic [31:0] rd_data_b,
	output logic [31:0] dbg_r1
);

	logic [31:0] regs [1:31];   // No storage for r0

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads, r0 is zero
	assign rd_data_a = (rd_addr_a == 5'd0) ? 32'd0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == 5'd0) ? 32'd0 : regs[rd_addr_b];
	assign dbg_r1    = regs[1];   // Loop counter tap

endmodule

// File: mmio.sv
// Data RAM and IO registers
`timescale 1ns/1ps
`include "game_consts.svh"

module mmio (
	input  logic              clock,
	input  logic              rst_n,
	input  logic [12:0]       addr,
	input  logic [31:0]       wdata,
	input  logic              we,
	input  logic [35:0]       gpio,
	output logic [31:0]       rdata,
	output game_pkg::player_t p1,
	output game_pkg::player_t p2,
	output logic [17:0]       leds
);

	localparam int RAM_AW = $clog2(`DMEM_DEPTH);

	logic [31:0]       ram [`DMEM_DEPTH];
	logic [31:0]       ctrl_q;       // Sampled controller word
	logic              is_io;
	logic [RAM_AW-1:0] ram_idx;

	assign is_io   = (addr >= `ADDR_CTRL);
	assign ram_idx = addr[RAM_AW-1:0];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			p1     <= '{x: 10'd0, y: `P1_Y};
			p2     <= '{x: 10'd0, y: `P2_Y};
		end else begin
			ctrl_q <= gpio[31:0];             // Resampled every cycle
			if (we && (addr == `ADDR_P1)) begin
				p1.x <= wdata[9:0];           // Row stays fixed
			end
			if (we && (addr == `ADDR_P2)) begin
				p2.x <= wdata[9:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (we && !is_io) begin
			ram[ram_idx] <= wdata;
		end
	end

	// Read data one cycle after address
	always_ff @(posedge clock) begin
		if (is_io) begin
			case (addr)
				`ADDR_CTRL: rdata <= ctrl_q;
				`ADDR_P1:   rdata <= {22'd0, p1.x};
				`ADDR_P2:   rdata <= {22'd0, p2.x};
				default:    rdata <= '0;   // Unmapped IO
			endcase
		end else begin
			rdata <= ram[ram_idx];
		end
	end

	assign leds = {16'd0, ctrl_q[1:0]};  // Two button mirror

endmodule

// File: vga_timing.sv
// VGA raster timing
`timescale 1ns/1ps
`include "game_consts.svh"

module vga_timing (
	input  logic               clock,
	input  logic               rst_n,
	output game_pkg::vga_pos_t pos
);

	localparam logic [9:0] H_LAST   = 10'(`H_TOTAL - 1);
	localparam logic [9:0] V_LAST   = 10'(`V_TOTAL - 1);
	localparam logic [9:0] HS_START = 10'(`H_ACTIVE + `H_FRONT);
	localparam logic [9:0] HS_END   = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT);
	localparam logic [9:0] VS_END   = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;                               // End of line
			v_cnt <= (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// Decode from counters, one pixel per clock
	assign pos.x      = h_cnt;
	assign pos.y      = v_cnt;
	assign pos.active = (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));
	assign pos.hs     = !((h_cnt >= HS_START) && (h_cnt < HS_END));
	assign pos.vs     = !((v_cnt >= VS_START) && (v_cnt < VS_END));

endmodule

// File: sprite_render.sv
// Player sprite renderer
`timescale 1ns/1ps
`include "game_consts.svh"

module sprite_render (
	input  logic               clock,
	input  logic               rst_n,
	input  game_pkg::vga_pos_t pos,
	input  game_pkg::player_t  p1,
	input  game_pkg::player_t  p2,
	output logic [7:0]         r,
	output logic [7:0]         g,
	output logic [7:0]         b,
	output logic               hs,
	output logic               vs,
	output logic               blank_n
);

	logic [23:0] color;

	function automatic logic in_box(input game_pkg::vga_pos_t p, input game_pkg::player_t pl);
		return (p.x >= pl.x) && (p.x < pl.x + 10'(`SPRITE_W)) &&
			(p.y >= pl.y) && (p.y < pl.y + 10'(`SPRITE_H));
	endfunction

	always_comb begin
		if (!pos.active) begin
			color = 24'd0;              // Black in blanking
		end else if (in_box(pos, p1)) begin
			color = `COLOR_P1;          // P1 drawn on top
		end else if (in_box(pos, p2)) begin
			color = `COLOR_P2;
		end else begin
			color = `COLOR_BG;
		end
	end

	// Color and syncs share the same one-cycle delay
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			{r, g, b} <= '0;
			hs        <= 1'b1;
			vs        <= 1'b1;
			blank_n   <= 1'b0;
		end else begin
			{r, g, b} <= color;
			hs        <= pos.hs;
			vs        <= pos.vs;
			blank_n   <= pos.active;
		end
	end

endmodule

// File: game_console.sv
// Game console top level
`timescale 1ns/1ps
`include "game_consts.svh"

module game_console (
	input  logic        clock,
	input  logic        rst_n,
	input  logic [35:0] gpio,          // Controller pins
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        vga_blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic [17:0] leds,
	output logic [31:0] instruction,   // Fetched word
	output logic [31:0] dbg_r1
);

	localparam int ROM_AW = $clog2(`IMEM_DEPTH);

	game_pkg::cpu_ctrl_t ctrl;
	game_pkg::instr_u    instr;
	game_pkg::vga_pos_t  pos;
	game_pkg::player_t   p1;
	game_pkg::player_t   p2;
	logic                zero;
	logic [11:0]         imem_addr;
	logic [31:0]         imem_q;
	logic [4:0]          rs_addr;
	logic [4:0]          rt_addr;
	logic [4:0]          rd_addr;
	logic [31:0]         reg_a;
	logic [31:0]         reg_b;
	logic [31:0]         wr_data;
	logic                reg_we;
	logic [12:0]         dmem_addr;
	logic [31:0]         dmem_wdata;
	logic [31:0]         dmem_q;
	logic                mem_we;
	logic [31:0]         rom [`IMEM_DEPTH];

	initial $readmemh("program.hex", rom);

	always_ff @(posedge clock) begin
		imem_q <= rom[imem_addr[ROM_AW-1:0]];   // One-cycle ROM read
	end

	assign instruction = imem_q;

	cpu_control u_ctrl (.clock, .rst_n, .instr, .zero, .ctrl);

	cpu_datapath u_dp (
		.clock, .rst_n, .ctrl, .imem_q, .reg_a, .reg_b, .dmem_q,
		.instr, .zero, .imem_addr, .rs_addr, .rt_addr, .rd_addr,
		.wr_data, .reg_we, .dmem_addr, .dmem_wdata, .mem_we
	);

	regfile u_rf (
		.clock, .rst_n, .we(reg_we), .wr_addr(rd_addr),
		.rd_addr_a(rs_addr), .rd_addr_b(rt_addr), .wr_data,
		.rd_data_a(reg_a), .rd_data_b(reg_b), .dbg_r1
	);

	mmio u_mmio (
		.clock, .rst_n, .addr(dmem_addr), .wdata(dmem_wdata), .we(mem_we),
		.gpio, .rdata(dmem_q), .p1, .p2, .leds
	);

	vga_timing u_vga (.clock, .rst_n, .pos);

	sprite_render u_spr (
		.clock, .rst_n, .pos, .p1, .p2,
		.r(vga_r), .g(vga_g), .b(vga_b),
		.hs(vga_hs), .vs(vga_vs), .blank_n(vga_blank_n)
	);

endmodule

// File: tb_game_console.sv
// Game console testbench
`timescale 1ns/1ps
`include "game_consts.svh"

module tb_game_console;

	localparam int          CLK_PERIOD    = 4;
	localparam int          RESET_CYCLES  = 4;
	localparam logic [31:0] SEED          = 32'h7eb3_ae3a;
	localparam int          FRAME_CYCLES  = `H_TOTAL * `V_TOTAL;
	localparam int          RUN_FRAMES    = 16;    // About 13 frames of tests plus slack
	localparam int          WATCHDOG_NS   = RUN_FRAMES * FRAME_CYCLES * CLK_PERIOD + 1000;
	localparam int          RESTART_LIMIT = 100;   // Cycles for r1 to count after reset
	localparam logic [31:0] FIRST_WORD    = {`OP_ADDI, 5'd3, 5'd0, 17'd63}; // addi r3, r0, 63

	typedef struct packed {
		logic hs;
		logic vs;
		logic blank_n;
	} sync_t;

	logic        clock;
	logic        rst_n;
	logic [35:0] gpio;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_blank_n;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;
	logic [17:0] leds;
	logic [31:0] instruction;
	logic [31:0] dbg_r1;

	logic [31:0] rng;
	int          fail_cnt      = 0;
	bit          color_req     = 1'b1;  // Stimulus asks for sprite checks
	int          exp_p1x       = 0;
	int          exp_p2x       = 0;
	bit          tracking      = 1'b0;  // Raster position known
	int          trk_h         = 0;
	int          trk_v         = 0;
	int          frame_cnt     = 0;
	bit          chk_color     = 1'b0;  // Latched at frame start
	int          chk_p1        = 0;
	int          chk_p2        = 0;
	logic        vs_prev       = 1'b1;
	logic        rst_prev      = 1'b0;
	logic [35:0] gpio_prev     = '0;
	logic [31:0] r1_prev       = '0;
	logic [31:0] r1_frame      = '0;
	bit          have_r1_frame = 1'b0;

	game_console dut (
		.clock, .rst_n, .gpio, .vga_hs, .vga_vs, .vga_blank_n,
		.vga_r, .vga_g, .vga_b, .leds, .instruction, .dbg_r1
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Expected syncs and blank for a raster position
	function automatic sync_t ref_sync(input int h, input int v);
		sync_t s;
		s.hs = !((h >= `H_ACTIVE + `H_FRONT) && (h < `H_ACTIVE + `H_FRONT + `H_SYNC));
		s.vs = !((v >= `V_ACTIVE + `V_FRONT) && (v < `V_ACTIVE + `V_FRONT + `V_SYNC));
		s.blank_n = (h < `H_ACTIVE) && (v < `V_ACTIVE);
		return s;
	endfunction

	// Expected color, p1 drawn over p2
	function automatic logic [23:0] ref_pixel(input int h, input int v, input int p1x,
			input int p2x);
		if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
			return 24'd0;
		end
		if (h >= p1x && h < p1x + `SPRITE_W && v >= `P1_Y && v < `P1_Y + `SPRITE_H) begin
			return `COLOR_P1;
		end
		if (h >= p2x && h < p2x + `SPRITE_W && v >= `P2_Y && v < `P2_Y + `SPRITE_H) begin
			return `COLOR_P2;
		end
		return `COLOR_BG;
	endfunction

	task automatic report_mismatch(input string name, input logic [35:0] got,
			input logic [35:0] exp);
		fail_cnt++;
		$display("[ERROR] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		fail_cnt++;
		$display("%0t ns: %s", $time, what);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	// Returns 1 ns after the edge that follows the next frame start
	task automatic wait_frame_start();
		int target;
		target = frame_cnt + 1;
		while (frame_cnt < target) @(posedge clock);
		#1;
	endtask

	task automatic wait_row(input int row);
		while (!(tracking && trk_v == row)) @(posedge clock);
		#1;
	endtask

	// Called 1 ns after an edge, or at time zero
	task automatic run_reset();
		rst_n = 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clock);
		@(negedge clock);
		assert (vga_hs == 1'b1) else report_mismatch("vga_hs", vga_hs, 1'b1);
		assert (vga_vs == 1'b1) else report_mismatch("vga_vs", vga_vs, 1'b1);
		assert (vga_blank_n == 1'b0) else report_mismatch("vga_blank_n", vga_blank_n, 1'b0);
		assert ({vga_r, vga_g, vga_b} == 24'd0)
			else report_mismatch("vga_rgb", {vga_r, vga_g, vga_b}, 24'd0);
		assert (dbg_r1 == 32'd0) else report_mismatch("dbg_r1", dbg_r1, 32'd0);
		assert (instruction == FIRST_WORD)
			else report_mismatch("instruction", instruction, FIRST_WORD);
		@(posedge clock);
		#1;
		rst_n = 1'b1;   // Last reset edge done
	endtask

	task automatic apply_random_gpio();
		logic [35:0] g;
		rng = xorshift32(rng);
		g[31:0] = rng;
		rng = xorshift32(rng);
		g[35:32] = rng[3:0];
		g[5:0] = 6'(rng[31:8] % 32'd57);     // Box stays inside the line
		rng = xorshift32(rng);
		g[21:16] = 6'(rng % 32'd57);
		gpio = g;
		color_req = 1'b0;                    // Players move in the next frame
	endtask

	// Comparing process, outputs settle well before the falling edge
	always @(negedge clock) begin
		sync_t       exp_sync;
		logic [23:0] exp_color;
		if (!rst_n) begin
			tracking      = 1'b0;
			have_r1_frame = 1'b0;
		end else begin
			if (rst_prev) begin
				assert (leds == {16'd0, gpio_prev[1:0]})
					else report_mismatch("leds", leds, {16'd0, gpio_prev[1:0]});
				assert (dbg_r1 >= r1_prev) else report_mismatch("dbg_r1", dbg_r1, r1_prev);
			end
			if (!tracking && vs_prev && !vga_vs) begin
				tracking = 1'b1;                     // First vsync pulse line
				trk_h    = 0;
				trk_v    = `V_ACTIVE + `V_FRONT;
			end
			if (tracking) begin
				if (trk_h == 0 && trk_v == 0) begin
					frame_cnt++;
					chk_color = color_req;
					chk_p1    = exp_p1x;
					chk_p2    = exp_p2x;
					if (have_r1_frame) begin
						assert (dbg_r1 > r1_frame)
							else report_mismatch("dbg_r1 frame growth", dbg_r1, r1_frame);
					end
					r1_frame      = dbg_r1;
					have_r1_frame = 1'b1;
				end
				exp_sync  = ref_sync(trk_h, trk_v);
				exp_color = ref_pixel(trk_h, trk_v, chk_p1, chk_p2);
				assert (vga_hs == exp_sync.hs) else report_mismatch("vga_hs", vga_hs, exp_sync.hs);
				assert (vga_vs == exp_sync.vs) else report_mismatch("vga_vs", vga_vs, exp_sync.vs);
				assert (vga_blank_n == exp_sync.blank_n)
					else report_mismatch("vga_blank_n", vga_blank_n, exp_sync.blank_n);
				if (chk_color || !exp_sync.blank_n) begin   // Blanked pixels always black
					assert ({vga_r, vga_g, vga_b} == exp_color)
						else report_mismatch("vga_rgb", {vga_r, vga_g, vga_b}, exp_color);
				end
				if (trk_h == `H_TOTAL - 1) begin
					trk_h = 0;
					trk_v = (trk_v == `V_TOTAL - 1) ? 0 : trk_v + 1;
				end else begin
					trk_h++;
				end
			end
		end
		vs_prev   = vga_vs;
		rst_prev  = rst_n;
		gpio_prev = gpio;
		r1_prev   = dbg_r1;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		int n;
		gpio  = '0;
		rst_n = 1'b0;
		rng   = SEED;
		run_reset();
		wait_frame_start();
		wait_frame_start();                  // One full frame with players at x 0
		for (int i = 0; i < 4; i++) begin
			wait_row(`V_ACTIVE);             // Move players in vertical blank
			apply_random_gpio();
			wait_frame_start();              // Settling frame
			exp_p1x   = gpio[5:0];
			exp_p2x   = gpio[21:16];
			color_req = 1'b1;
			wait_frame_start();              // This frame is fully compared
		end
		wait_row(`V_ACTIVE);
		wait_row(20);                        // Mid frame
		run_reset();
		n = 0;
		while (dbg_r1 == 32'd0 && n < RESTART_LIMIT) begin
			@(negedge clock);
			n++;
		end
		assert (n < RESTART_LIMIT) else report_failure("register 1 did not count after reset");
		assert (dbg_r1 == 32'd1) else report_mismatch("dbg_r1", dbg_r1, 32'd1);
		@(posedge clock);
		#1;
		wait_frame_start();
		wait_frame_start();                  // Full frame after the restart
		if (fail_cnt == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// File: program.hex
// One 32-bit instruction word per line, loaded from ROM address 0 upward
// Fields are opcode[31:27] rd[26:22] rs[21:17] then rt/shamt/funct or imm[16:0]
28C0003F  // 0: addi r3, r0, 63      mask for the x fields
28420001  // 1: addi r1, r1, 1       loop counter
40801000  // 2: lw   r2, 0x1000(r0)  controller word
01043002  // 3: and  r4, r2, r3      bits 5:0
39001001  // 4: sw   r4, 0x1001(r0)  p1.x
01440805  // 5: sra  r5, r2, 16
014A3002  // 6: and  r5, r5, r3      bits 21:16
39401002  // 7: sw   r5, 0x1002(r0)  p2.x
08000001  // 8: j    1

// File: src.f
+incdir+.
game_pkg.sv
cpu_control.sv
cpu_datapath.sv
regfile.sv
mmio.sv
vga_timing.sv
sprite_render.sv
game_console.sv
tb_game_console.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_game_console \
	-o tb_sim || exit 1
./obj_dir/tb_sim 2>&1 | tee sim.log
! grep -q "Testbench failed" sim.log && grep -q "Testbench passed" sim.log \
	&& echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
